//--- filelist.f
verilog/crypt_pkg.sv
verilog/scratch_mem.sv
verilog/mem_arbiter.sv
verilog/block_mixer.sv
verilog/block_fetch.sv
verilog/block_store.sv
verilog/crypt_fsm.sv
verilog/crypt_ctrl_regs.sv
verilog/crypt_top.sv
sim/tb_crypt.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the testbench with Verilator, then check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module tb_crypt -o tb_crypt
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/tb_crypt > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
  exit 0
fi
exit 1

//--- sim/tb_crypt.sv
`timescale 1ns/1ps

module tb_crypt;

  // About 40 bus transactions per job over 8 jobs with a large margin each
  localparam int MAX_CYCLES = 20000;

  logic                             clk;
  logic                             reset_n;
  logic [crypt_pkg::AXI_ADDR_W-1:0] s_axi_awaddr;
  logic                             s_axi_awvalid;
  logic                             s_axi_awready;
  crypt_pkg::word_t                 s_axi_wdata;
  logic                             s_axi_wvalid;
  logic                             s_axi_wready;
  logic [1:0]                       s_axi_bresp;
  logic                             s_axi_bvalid;
  logic                             s_axi_bready;
  logic [crypt_pkg::AXI_ADDR_W-1:0] s_axi_araddr;
  logic                             s_axi_arvalid;
  logic                             s_axi_arready;
  crypt_pkg::word_t                 s_axi_rdata;
  logic [1:0]                       s_axi_rresp;
  logic                             s_axi_rvalid;
  logic                             s_axi_rready;
  int                               checks = 0;
  int                               errors = 0;
  int                               cycles = 0;

  crypt_top dut_i (
    .clk, .reset_n,
    .s_axi_awaddr, .s_axi_awvalid, .s_axi_awready,
    .s_axi_wdata, .s_axi_wvalid, .s_axi_wready,
    .s_axi_bresp, .s_axi_bvalid, .s_axi_bready,
    .s_axi_araddr, .s_axi_arvalid, .s_axi_arready,
    .s_axi_rdata, .s_axi_rresp, .s_axi_rvalid, .s_axi_rready
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("TB FAILED");
      $finish;
    end
  end

  // Expected cipher as key XOR and 8-bit rotate left per round
  function automatic logic [127:0] ref_cipher(logic [127:0] pt, logic [127:0] key);
    logic [127:0] b;
    b = pt;
    for (int r = 0; r < crypt_pkg::N_ROUNDS; r++) begin
      b = b ^ key;
      b = (b << 8) | (b >> 120);
    end
    return b;
  endfunction

  function automatic logic [11:0] mem_byte_addr(crypt_pkg::mem_addr_t idx);
    return crypt_pkg::MEM_BASE + {4'd0, idx, 2'b00};
  endfunction

  // Index 0 is SRC and 1 is DST and 2 to 5 are the key words
  function automatic logic [11:0] reg_by_index(int i);
    if (i == 0) return crypt_pkg::REG_SRC;
    if (i == 1) return crypt_pkg::REG_DST;
    return crypt_pkg::REG_KEY0 + 12'(4 * (i - 2));
  endfunction

  task automatic check_word(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("FAILED %s: expected %08h, actual %08h", name, expected, actual);
    end
  endtask

  // Called and returns on a falling edge
  task automatic axi_write(input logic [11:0] addr, input logic [31:0] data);
    s_axi_awaddr  = addr;
    s_axi_wdata   = data;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    s_axi_bready  = 1'b1;
    @(negedge clk);
    while (!s_axi_awready) @(negedge clk);
    check_word("write data ready", 32'h1, {31'd0, s_axi_wready});
    @(negedge clk);
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    while (!s_axi_bvalid) @(negedge clk);
    check_word("write response", 32'h0, {30'd0, s_axi_bresp});
    @(negedge clk);
    s_axi_bready = 1'b0;
  endtask

  task automatic axi_read(input logic [11:0] addr, output logic [31:0] data);
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    s_axi_rready  = 1'b1;
    @(negedge clk);
    while (!s_axi_arready) @(negedge clk);
    @(negedge clk);
    s_axi_arvalid = 1'b0;
    while (!s_axi_rvalid) @(negedge clk);
    data = s_axi_rdata;
    check_word("read response", 32'h0, {30'd0, s_axi_rresp});
    @(negedge clk);
    s_axi_rready = 1'b0;
  endtask

  task automatic wait_done(output logic [31:0] status);
    status = 32'h0;
    while (!status[1]) axi_read(crypt_pkg::REG_STATUS, status);
  endtask

  // Random plaintext and key loaded along with the job registers
  task automatic setup_job(input crypt_pkg::mem_addr_t src, input crypt_pkg::mem_addr_t dst,
                           output logic [127:0] pt, output logic [127:0] key);
    for (int i = 0; i < 4; i++) begin
      pt[i*32 +: 32]  = $urandom;
      key[i*32 +: 32] = $urandom;
    end
    for (int i = 0; i < 4; i++) begin
      axi_write(mem_byte_addr(src + 6'(i)), pt[i*32 +: 32]);
    end
    axi_write(crypt_pkg::REG_SRC, 32'(src));
    axi_write(crypt_pkg::REG_DST, 32'(dst));
    for (int i = 0; i < 4; i++) begin
      axi_write(reg_by_index(i + 2), key[i*32 +: 32]);
    end
  endtask

  task automatic verify_job(input string name, input crypt_pkg::mem_addr_t src,
                            input crypt_pkg::mem_addr_t dst, input logic [127:0] pt,
                            input logic [127:0] key);
    logic [127:0] exp;
    logic [31:0]  rd;
    exp = ref_cipher(pt, key);
    for (int i = 0; i < 4; i++) begin
      axi_read(mem_byte_addr(dst + 6'(i)), rd);
      check_word($sformatf("%s result word %0d", name, i), exp[i*32 +: 32], rd);
    end
    // Source block must be untouched
    for (int i = 0; i < 4; i++) begin
      axi_read(mem_byte_addr(src + 6'(i)), rd);
      check_word($sformatf("%s source word %0d", name, i), pt[i*32 +: 32], rd);
    end
  endtask

  task automatic run_job(input string name, input crypt_pkg::mem_addr_t src,
                         input crypt_pkg::mem_addr_t dst);
    logic [127:0] pt;
    logic [127:0] key;
    logic [31:0]  status;
    setup_job(src, dst, pt, key);
    axi_write(crypt_pkg::REG_CTRL, 32'h1);
    wait_done(status);
    check_word({name, " busy after done"}, 32'h0, {31'd0, status[0]});
    verify_job(name, src, dst, pt, key);
  endtask

  initial begin
    logic [31:0]  rd;
    logic [31:0]  vals [6];
    logic [31:0]  words [16];
    logic [127:0] pt;
    logic [127:0] key;
    int           s_slot;
    int           d_slot;
    clk           = 1'b0;
    reset_n       = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    void'($urandom(15));
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
    @(negedge clk);

    // Register readback
    axi_read(crypt_pkg::REG_STATUS, rd);
    check_word("status after reset", 32'h0, rd);
    for (int i = 0; i < 6; i++) begin
      vals[i] = (i < 2) ? ($urandom % 64) : $urandom;
      axi_write(reg_by_index(i), vals[i]);
    end
    for (int i = 0; i < 6; i++) begin
      axi_read(reg_by_index(i), rd);
      check_word($sformatf("register readback %0d", i), vals[i], rd);
    end

    // Memory window on the upper 16 words
    for (int i = 0; i < 16; i++) begin
      words[i] = $urandom;
      axi_write(mem_byte_addr(6'(48 + i)), words[i]);
    end
    for (int i = 0; i < 16; i++) begin
      axi_read(mem_byte_addr(6'(48 + i)), rd);
      check_word($sformatf("memory word %0d", 48 + i), words[i], rd);
    end

    run_job("single job", 6'd0, 6'd8);

    // Source and destination slots never overlap
    for (int j = 0; j < 6; j++) begin
      s_slot = $urandom % 16;
      d_slot = (s_slot + 1 + ($urandom % 15)) % 16;
      run_job($sformatf("job %0d", j), 6'(s_slot * 4), 6'(d_slot * 4));
    end

    // Second start lands while busy
    setup_job(6'd16, 6'd32, pt, key);
    axi_write(crypt_pkg::REG_CTRL, 32'h1);
    axi_write(crypt_pkg::REG_CTRL, 32'h1);
    axi_read(crypt_pkg::REG_STATUS, rd);
    check_word("done cleared by start", 32'h0, {31'd0, rd[1]});
    wait_done(rd);
    // No second job may follow the first one
    axi_read(crypt_pkg::REG_STATUS, rd);
    check_word("double start idle", 32'h2, rd);
    verify_job("double start", 6'd16, 6'd32, pt, key);

    // Soft clear in the middle of a job
    setup_job(6'd20, 6'd40, pt, key);
    axi_write(crypt_pkg::REG_CTRL, 32'h1);
    axi_write(crypt_pkg::REG_CTRL, 32'h2);
    axi_read(crypt_pkg::REG_STATUS, rd);
    check_word("status after clear", 32'h0, rd);
    run_job("job after clear", 6'd20, 6'd40);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- verilog/block_fetch.sv
`timescale 1ns/1ps

module block_fetch (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 clear_i,
  input  logic                 start_i,
  input  crypt_pkg::mem_addr_t base_i,
  input  logic                 gnt_i,
  input  logic                 rvalid_i,
  input  crypt_pkg::word_t     rdata_i,
  output logic                 req_o,
  output crypt_pkg::mem_addr_t addr_o,
  output crypt_pkg::block_t    block_o,
  output logic                 done_o
);

  logic                          active_q;
  logic [crypt_pkg::LANE_W:0]    req_cnt_q;
  logic [crypt_pkg::LANE_W-1:0]  rsp_cnt_q;
  crypt_pkg::mem_addr_t          base_q;
  crypt_pkg::block_t             block_q;
  logic [crypt_pkg::LANE_W:0]    req_idx;

  // First request goes out in the start cycle itself
  assign req_idx = start_i ? '0 : req_cnt_q;
  assign req_o   = start_i | (active_q & ~req_cnt_q[crypt_pkg::LANE_W]);
  assign addr_o  = (start_i ? base_i : base_q) +
                   crypt_pkg::mem_addr_t'(req_idx[crypt_pkg::LANE_W-1:0]);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      active_q  <= 1'b0;
      req_cnt_q <= '0;
      rsp_cnt_q <= '0;
      base_q    <= '0;
      done_o    <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (clear_i) begin
        active_q <= 1'b0;
      end else if (start_i) begin
        active_q  <= 1'b1;
        base_q    <= base_i;
        req_cnt_q <= (crypt_pkg::LANE_W+1)'(gnt_i);
        rsp_cnt_q <= '0;
      end else if (active_q) begin
        if (gnt_i) begin
          req_cnt_q <= req_cnt_q + 1'b1;
        end
        if (rvalid_i) begin
          rsp_cnt_q <= rsp_cnt_q + 1'b1;
          if (rsp_cnt_q == '1) begin
            active_q <= 1'b0;
            done_o   <= 1'b1;
          end
        end
      end
    end
  end

  // Returned words land in their lane, word 0 lowest
  always_ff @(posedge clk) begin
    if (active_q && rvalid_i) begin
      block_q[rsp_cnt_q * crypt_pkg::WORD_W +: crypt_pkg::WORD_W] <= rdata_i;
    end
  end

  assign block_o = block_q;

endmodule

//--- verilog/block_mixer.sv
`timescale 1ns/1ps

module block_mixer (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              start_i,
  input  crypt_pkg::block_t block_i,
  input  crypt_pkg::block_t key_i,
  output crypt_pkg::block_t block_o,
  output logic              done_o
);

  logic                              run_q;
  logic [crypt_pkg::ROUND_CNT_W-1:0] rnd_cnt_q;
  crypt_pkg::block_t                 block_q;

  // Key XOR, then rotate the whole block left
  function automatic crypt_pkg::block_t mix_round(crypt_pkg::block_t blk,
                                                  crypt_pkg::block_t key);
    crypt_pkg::block_t x;
    x = blk ^ key;
    return {x[crypt_pkg::BLOCK_W-crypt_pkg::ROT_BITS-1:0],
            x[crypt_pkg::BLOCK_W-1 -: crypt_pkg::ROT_BITS]};
  endfunction

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      run_q     <= 1'b0;
      rnd_cnt_q <= '0;
      done_o    <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i) begin
        // First round is applied at load
        run_q     <= 1'b1;
        rnd_cnt_q <= crypt_pkg::ROUND_CNT_W'(1);
      end else if (run_q) begin
        rnd_cnt_q <= rnd_cnt_q + 1'b1;
        if (rnd_cnt_q == crypt_pkg::ROUND_CNT_W'(crypt_pkg::N_ROUNDS - 1)) begin
          run_q  <= 1'b0;
          done_o <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      block_q <= mix_round(block_i, key_i);
    end else if (run_q) begin
      block_q <= mix_round(block_q, key_i);
    end
  end

  assign block_o = block_q;

endmodule

//--- verilog/block_store.sv
`timescale 1ns/1ps

module block_store (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 clear_i,
  input  logic                 start_i,
  input  crypt_pkg::mem_addr_t base_i,
  input  crypt_pkg::block_t    block_i,
  input  logic                 gnt_i,
  output logic                 req_o,
  output crypt_pkg::mem_addr_t addr_o,
  output crypt_pkg::word_t     wdata_o,
  output logic                 done_o
);

  logic                         active_q;
  logic [crypt_pkg::LANE_W-1:0] cnt_q;
  crypt_pkg::mem_addr_t         base_q;

  assign req_o   = active_q;
  assign addr_o  = base_q + crypt_pkg::mem_addr_t'(cnt_q);
  // Lane select follows the word counter
  assign wdata_o = block_i[cnt_q * crypt_pkg::WORD_W +: crypt_pkg::WORD_W];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      active_q <= 1'b0;
      cnt_q    <= '0;
      base_q   <= '0;
      done_o   <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (clear_i) begin
        active_q <= 1'b0;
      end else if (start_i) begin
        active_q <= 1'b1;
        cnt_q    <= '0;
        base_q   <= base_i;
      end else if (active_q && gnt_i) begin
        cnt_q <= cnt_q + 1'b1;
        if (cnt_q == '1) begin
          active_q <= 1'b0;
          done_o   <= 1'b1;
        end
      end
    end
  end

endmodule

//--- verilog/crypt_ctrl_regs.sv
`timescale 1ns/1ps

module crypt_ctrl_regs (
  input  logic                                 clk,
  input  logic                                 reset_n,
  input  logic [crypt_pkg::AXI_ADDR_W-1:0]     s_axi_awaddr,
  input  logic                                 s_axi_awvalid,
  output logic                                 s_axi_awready,
  input  crypt_pkg::word_t                     s_axi_wdata,
  input  logic                                 s_axi_wvalid,
  output logic                                 s_axi_wready,
  output logic [1:0]                           s_axi_bresp,
  output logic                                 s_axi_bvalid,
  input  logic                                 s_axi_bready,
  input  logic [crypt_pkg::AXI_ADDR_W-1:0]     s_axi_araddr,
  input  logic                                 s_axi_arvalid,
  output logic                                 s_axi_arready,
  output crypt_pkg::word_t                     s_axi_rdata,
  output logic [1:0]                           s_axi_rresp,
  output logic                                 s_axi_rvalid,
  input  logic                                 s_axi_rready,
  input  logic                                 job_done_i,
  input  logic                                 busy_i,
  input  logic                                 bus_gnt_i,
  input  logic                                 bus_rvalid_i,
  input  crypt_pkg::word_t                     mem_rdata_i,
  output logic                                 job_start_o,
  output logic                                 job_clear_o,
  output crypt_pkg::mem_addr_t                 src_addr_o,
  output crypt_pkg::mem_addr_t                 dst_addr_o,
  output crypt_pkg::block_t                    key_o,
  output logic                                 bus_req_o,
  output logic                                 bus_we_o,
  output crypt_pkg::mem_addr_t                 bus_addr_o,
  output crypt_pkg::word_t                     bus_wdata_o
);

  logic                 aw_acc_q, ar_acc_q;
  logic                 bvalid_q, rvalid_q;
  logic                 wr_pend_q, rd_req_q, rd_wait_q;
  logic                 done_q;
  crypt_pkg::mem_addr_t src_q, dst_q;
  crypt_pkg::block_t    key_q;
  crypt_pkg::mem_addr_t wr_addr_q, rd_addr_q;
  crypt_pkg::word_t     wr_data_q, rd_data_q;
  crypt_pkg::word_t     reg_rdata;

  // Byte address inside the scratch memory window
  function automatic logic is_mem(logic [crypt_pkg::AXI_ADDR_W-1:0] addr);
    return (addr >= crypt_pkg::MEM_BASE) &&
           (addr < crypt_pkg::MEM_BASE + 12'(4 * crypt_pkg::MEM_WORDS));
  endfunction

  always_comb begin
    case (s_axi_araddr)
      crypt_pkg::REG_STATUS: reg_rdata = {30'd0, done_q, busy_i};
      crypt_pkg::REG_SRC:    reg_rdata = crypt_pkg::word_t'(src_q);
      crypt_pkg::REG_DST:    reg_rdata = crypt_pkg::word_t'(dst_q);
      crypt_pkg::REG_KEY0:   reg_rdata = key_q[0*crypt_pkg::WORD_W +: crypt_pkg::WORD_W];
      crypt_pkg::REG_KEY1:   reg_rdata = key_q[1*crypt_pkg::WORD_W +: crypt_pkg::WORD_W];
      crypt_pkg::REG_KEY2:   reg_rdata = key_q[2*crypt_pkg::WORD_W +: crypt_pkg::WORD_W];
      crypt_pkg::REG_KEY3:   reg_rdata = key_q[3*crypt_pkg::WORD_W +: crypt_pkg::WORD_W];
      default:               reg_rdata = '0;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      aw_acc_q    <= 1'b0;
      ar_acc_q    <= 1'b0;
      bvalid_q    <= 1'b0;
      rvalid_q    <= 1'b0;
      wr_pend_q   <= 1'b0;
      rd_req_q    <= 1'b0;
      rd_wait_q   <= 1'b0;
      done_q      <= 1'b0;
      job_start_o <= 1'b0;
      job_clear_o <= 1'b0;
      src_q       <= '0;
      dst_q       <= '0;
      key_q       <= '0;
    end else begin
      job_start_o <= 1'b0;
      job_clear_o <= 1'b0;
      // AW and W taken together, one outstanding write, never beside a pending read
      aw_acc_q <= s_axi_awvalid & s_axi_wvalid & ~aw_acc_q & ~bvalid_q & ~wr_pend_q &
                  ~rd_req_q & ~ar_acc_q;
      ar_acc_q <= s_axi_arvalid & ~ar_acc_q & ~rd_req_q & ~rd_wait_q & ~rvalid_q &
                  ~wr_pend_q & ~aw_acc_q;
      if (bvalid_q && s_axi_bready) begin
        bvalid_q <= 1'b0;
      end
      if (rvalid_q && s_axi_rready) begin
        rvalid_q <= 1'b0;
      end
      if (job_done_i) begin
        done_q <= 1'b1;
      end

      if (aw_acc_q) begin
        if (is_mem(s_axi_awaddr)) begin
          wr_pend_q <= 1'b1;
        end else begin
          bvalid_q <= 1'b1;
          case (s_axi_awaddr)
            crypt_pkg::REG_CTRL: begin
              job_start_o <= s_axi_wdata[0] & ~busy_i;
              job_clear_o <= s_axi_wdata[1];
              if (s_axi_wdata[1] || (s_axi_wdata[0] && !busy_i)) begin
                done_q <= 1'b0;
              end
            end
            crypt_pkg::REG_SRC:  src_q <= s_axi_wdata[crypt_pkg::MEM_AW-1:0];
            crypt_pkg::REG_DST:  dst_q <= s_axi_wdata[crypt_pkg::MEM_AW-1:0];
            crypt_pkg::REG_KEY0: key_q[0*crypt_pkg::WORD_W +: crypt_pkg::WORD_W] <= s_axi_wdata;
            crypt_pkg::REG_KEY1: key_q[1*crypt_pkg::WORD_W +: crypt_pkg::WORD_W] <= s_axi_wdata;
            crypt_pkg::REG_KEY2: key_q[2*crypt_pkg::WORD_W +: crypt_pkg::WORD_W] <= s_axi_wdata;
            crypt_pkg::REG_KEY3: key_q[3*crypt_pkg::WORD_W +: crypt_pkg::WORD_W] <= s_axi_wdata;
            default: ;
          endcase
        end
      end

      if (ar_acc_q) begin
        if (is_mem(s_axi_araddr)) begin
          rd_req_q <= 1'b1;
        end else begin
          rvalid_q <= 1'b1;
        end
      end

      // Memory window, the write goes first when both are pending
      if (bus_gnt_i) begin
        if (wr_pend_q) begin
          wr_pend_q <= 1'b0;
          bvalid_q  <= 1'b1;
        end else begin
          rd_req_q  <= 1'b0;
          rd_wait_q <= 1'b1;
        end
      end
      if (rd_wait_q && bus_rvalid_i) begin
        rd_wait_q <= 1'b0;
        rvalid_q  <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_acc_q) begin
      wr_addr_q <= s_axi_awaddr[crypt_pkg::MEM_AW+1:2];
      wr_data_q <= s_axi_wdata;
    end
    if (ar_acc_q) begin
      rd_addr_q <= s_axi_araddr[crypt_pkg::MEM_AW+1:2];
      rd_data_q <= reg_rdata;
    end else if (rd_wait_q && bus_rvalid_i) begin
      rd_data_q <= mem_rdata_i;
    end
  end

  assign s_axi_awready = aw_acc_q;
  assign s_axi_wready  = aw_acc_q;
  assign s_axi_arready = ar_acc_q;
  assign s_axi_bvalid  = bvalid_q;
  assign s_axi_rvalid  = rvalid_q;
  assign s_axi_rdata   = rd_data_q;
  assign s_axi_bresp   = 2'b00;
  assign s_axi_rresp   = 2'b00;

  assign bus_req_o   = wr_pend_q | rd_req_q;
  assign bus_we_o    = wr_pend_q;
  assign bus_addr_o  = wr_pend_q ? wr_addr_q : rd_addr_q;
  assign bus_wdata_o = wr_data_q;

  assign src_addr_o = src_q;
  assign dst_addr_o = dst_q;
  assign key_o      = key_q;

endmodule

//--- verilog/crypt_fsm.sv
`timescale 1ns/1ps

module crypt_fsm (
  input  logic clk,
  input  logic reset_n,
  input  logic clear_i,
  input  logic job_start_i,
  input  logic fetch_done_i,
  input  logic mix_done_i,
  input  logic store_done_i,
  output logic fetch_start_o,
  output logic mix_start_o,
  output logic store_start_o,
  output logic job_done_o,
  output logic busy_o
);

  crypt_pkg::crypt_state_t current_state, next_state;
  // High in the first cycle after a state change
  logic entry_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      current_state <= crypt_pkg::CR_IDLE;
      entry_q       <= 1'b0;
    end else if (clear_i) begin
      current_state <= crypt_pkg::CR_IDLE;
      entry_q       <= 1'b0;
    end else begin
      current_state <= next_state;
      entry_q       <= (next_state != current_state);
    end
  end

  always_comb begin
    next_state = current_state;
    case (current_state)
      crypt_pkg::CR_IDLE: begin
        if (job_start_i) begin
          next_state = crypt_pkg::CR_FETCH;
        end
      end
      crypt_pkg::CR_FETCH: begin
        if (fetch_done_i) begin
          next_state = crypt_pkg::CR_MIX;
        end
      end
      crypt_pkg::CR_MIX: begin
        if (mix_done_i) begin
          next_state = crypt_pkg::CR_STORE;
        end
      end
      crypt_pkg::CR_STORE: begin
        if (store_done_i) begin
          next_state = crypt_pkg::CR_DONE;
        end
      end
      crypt_pkg::CR_DONE: next_state = crypt_pkg::CR_IDLE;
      default:            next_state = crypt_pkg::CR_IDLE;
    endcase
  end

  // Start pulses on state entry
  always_comb begin
    fetch_start_o = entry_q && (current_state == crypt_pkg::CR_FETCH);
    mix_start_o   = entry_q && (current_state == crypt_pkg::CR_MIX);
    store_start_o = entry_q && (current_state == crypt_pkg::CR_STORE);
    job_done_o    = (current_state == crypt_pkg::CR_DONE);
    busy_o        = (current_state != crypt_pkg::CR_IDLE);
  end

endmodule

//--- verilog/crypt_pkg.sv
package crypt_pkg;

  // Data path widths
  localparam int WORD_W          = 32;
  localparam int WORDS_PER_BLOCK = 4;
  localparam int BLOCK_W         = WORD_W * WORDS_PER_BLOCK;
  localparam int LANE_W          = $clog2(WORDS_PER_BLOCK);
  localparam int MEM_WORDS       = 64;
  localparam int MEM_AW          = $clog2(MEM_WORDS);

  // Mixer rounds
  localparam int N_ROUNDS    = 4;
  localparam int ROUND_CNT_W = $clog2(N_ROUNDS + 1);
  localparam int ROT_BITS    = 8;

  typedef logic [WORD_W-1:0]  word_t;
  typedef logic [BLOCK_W-1:0] block_t;
  typedef logic [MEM_AW-1:0]  mem_addr_t;

  // Host register map, byte offsets
  localparam int AXI_ADDR_W = 12;
  localparam logic [AXI_ADDR_W-1:0] REG_CTRL   = 12'h000;
  localparam logic [AXI_ADDR_W-1:0] REG_STATUS = 12'h004;
  localparam logic [AXI_ADDR_W-1:0] REG_SRC    = 12'h008;
  localparam logic [AXI_ADDR_W-1:0] REG_DST    = 12'h00C;
  localparam logic [AXI_ADDR_W-1:0] REG_KEY0   = 12'h010;
  localparam logic [AXI_ADDR_W-1:0] REG_KEY1   = 12'h014;
  localparam logic [AXI_ADDR_W-1:0] REG_KEY2   = 12'h018;
  localparam logic [AXI_ADDR_W-1:0] REG_KEY3   = 12'h01C;
  localparam logic [AXI_ADDR_W-1:0] MEM_BASE   = 12'h100;

  typedef enum logic [2:0] {
    CR_IDLE,
    CR_FETCH,
    CR_MIX,
    CR_STORE,
    CR_DONE
  } crypt_state_t;

endpackage

//--- verilog/crypt_top.sv
`timescale 1ns/1ps

module crypt_top (
  input  logic                             clk,
  input  logic                             reset_n,
  input  logic [crypt_pkg::AXI_ADDR_W-1:0] s_axi_awaddr,
  input  logic                             s_axi_awvalid,
  output logic                             s_axi_awready,
  input  crypt_pkg::word_t                 s_axi_wdata,
  input  logic                             s_axi_wvalid,
  output logic                             s_axi_wready,
  output logic [1:0]                       s_axi_bresp,
  output logic                             s_axi_bvalid,
  input  logic                             s_axi_bready,
  input  logic [crypt_pkg::AXI_ADDR_W-1:0] s_axi_araddr,
  input  logic                             s_axi_arvalid,
  output logic                             s_axi_arready,
  output crypt_pkg::word_t                 s_axi_rdata,
  output logic [1:0]                       s_axi_rresp,
  output logic                             s_axi_rvalid,
  input  logic                             s_axi_rready
);

  logic                 job_start, job_clear, job_done, busy;
  crypt_pkg::mem_addr_t src_addr, dst_addr;
  crypt_pkg::block_t    key;
  logic                 fetch_start, mix_start, store_start;
  logic                 fetch_done, mix_done, store_done;
  crypt_pkg::block_t    fetch_block, mix_block;
  logic                 fetch_req, fetch_gnt, fetch_rvalid;
  crypt_pkg::mem_addr_t fetch_addr;
  logic                 store_req, store_gnt;
  crypt_pkg::mem_addr_t store_addr;
  crypt_pkg::word_t     store_wdata;
  logic                 bus_req, bus_we, bus_gnt, bus_rvalid;
  crypt_pkg::mem_addr_t bus_addr;
  crypt_pkg::word_t     bus_wdata;
  logic                 mem_en, mem_we;
  crypt_pkg::mem_addr_t mem_addr;
  crypt_pkg::word_t     mem_wdata, mem_rdata;

  crypt_ctrl_regs regs_i (
    .clk, .reset_n,
    .s_axi_awaddr, .s_axi_awvalid, .s_axi_awready,
    .s_axi_wdata, .s_axi_wvalid, .s_axi_wready,
    .s_axi_bresp, .s_axi_bvalid, .s_axi_bready,
    .s_axi_araddr, .s_axi_arvalid, .s_axi_arready,
    .s_axi_rdata, .s_axi_rresp, .s_axi_rvalid, .s_axi_rready,
    .job_done_i(job_done), .busy_i(busy),
    .bus_gnt_i(bus_gnt), .bus_rvalid_i(bus_rvalid), .mem_rdata_i(mem_rdata),
    .job_start_o(job_start), .job_clear_o(job_clear),
    .src_addr_o(src_addr), .dst_addr_o(dst_addr), .key_o(key),
    .bus_req_o(bus_req), .bus_we_o(bus_we), .bus_addr_o(bus_addr),
    .bus_wdata_o(bus_wdata)
  );

  crypt_fsm fsm_i (
    .clk, .reset_n, .clear_i(job_clear), .job_start_i(job_start),
    .fetch_done_i(fetch_done), .mix_done_i(mix_done), .store_done_i(store_done),
    .fetch_start_o(fetch_start), .mix_start_o(mix_start), .store_start_o(store_start),
    .job_done_o(job_done), .busy_o(busy)
  );

  block_fetch fetch_i (
    .clk, .reset_n, .clear_i(job_clear), .start_i(fetch_start), .base_i(src_addr),
    .gnt_i(fetch_gnt), .rvalid_i(fetch_rvalid), .rdata_i(mem_rdata),
    .req_o(fetch_req), .addr_o(fetch_addr), .block_o(fetch_block), .done_o(fetch_done)
  );

  block_mixer mixer_i (
    .clk, .reset_n, .start_i(mix_start), .block_i(fetch_block), .key_i(key),
    .block_o(mix_block), .done_o(mix_done)
  );

  block_store store_i (
    .clk, .reset_n, .clear_i(job_clear), .start_i(store_start), .base_i(dst_addr),
    .block_i(mix_block), .gnt_i(store_gnt),
    .req_o(store_req), .addr_o(store_addr), .wdata_o(store_wdata), .done_o(store_done)
  );

  mem_arbiter arb_i (
    .clk, .reset_n,
    .fetch_req_i(fetch_req), .fetch_we_i(1'b0), .fetch_addr_i(fetch_addr),
    .fetch_wdata_i('0),
    .store_req_i(store_req), .store_we_i(1'b1), .store_addr_i(store_addr),
    .store_wdata_i(store_wdata),
    .bus_req_i(bus_req), .bus_we_i(bus_we), .bus_addr_i(bus_addr), .bus_wdata_i(bus_wdata),
    .fetch_gnt_o(fetch_gnt), .store_gnt_o(store_gnt), .bus_gnt_o(bus_gnt),
    .fetch_rvalid_o(fetch_rvalid), .store_rvalid_o(), .bus_rvalid_o(bus_rvalid),
    .mem_en_o(mem_en), .mem_we_o(mem_we), .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata)
  );

  scratch_mem #(
    .ADDR_W(crypt_pkg::MEM_AW),
    .DATA_W(crypt_pkg::WORD_W)
  ) mem_i (
    .clk, .en_i(mem_en), .we_i(mem_we), .addr_i(mem_addr),
    .wdata_i(mem_wdata), .rdata_o(mem_rdata)
  );

endmodule

//--- verilog/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 fetch_req_i,
  input  logic                 fetch_we_i,
  input  crypt_pkg::mem_addr_t fetch_addr_i,
  input  crypt_pkg::word_t     fetch_wdata_i,
  input  logic                 store_req_i,
  input  logic                 store_we_i,
  input  crypt_pkg::mem_addr_t store_addr_i,
  input  crypt_pkg::word_t     store_wdata_i,
  input  logic                 bus_req_i,
  input  logic                 bus_we_i,
  input  crypt_pkg::mem_addr_t bus_addr_i,
  input  crypt_pkg::word_t     bus_wdata_i,
  output logic                 fetch_gnt_o,
  output logic                 store_gnt_o,
  output logic                 bus_gnt_o,
  output logic                 fetch_rvalid_o,
  output logic                 store_rvalid_o,
  output logic                 bus_rvalid_o,
  output logic                 mem_en_o,
  output logic                 mem_we_o,
  output crypt_pkg::mem_addr_t mem_addr_o,
  output crypt_pkg::word_t     mem_wdata_o
);

  // Fixed priority: fetch, store, host bus
  always_comb begin
    fetch_gnt_o = 1'b0;
    store_gnt_o = 1'b0;
    bus_gnt_o   = 1'b0;
    mem_we_o    = 1'b0;
    mem_addr_o  = '0;
    mem_wdata_o = '0;
    if (fetch_req_i) begin
      fetch_gnt_o = 1'b1;
      mem_we_o    = fetch_we_i;
      mem_addr_o  = fetch_addr_i;
      mem_wdata_o = fetch_wdata_i;
    end else if (store_req_i) begin
      store_gnt_o = 1'b1;
      mem_we_o    = store_we_i;
      mem_addr_o  = store_addr_i;
      mem_wdata_o = store_wdata_i;
    end else if (bus_req_i) begin
      bus_gnt_o   = 1'b1;
      mem_we_o    = bus_we_i;
      mem_addr_o  = bus_addr_i;
      mem_wdata_o = bus_wdata_i;
    end
  end

  assign mem_en_o = fetch_gnt_o | store_gnt_o | bus_gnt_o;

  // Read owner, data returns next cycle
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      fetch_rvalid_o <= 1'b0;
      store_rvalid_o <= 1'b0;
      bus_rvalid_o   <= 1'b0;
    end else begin
      fetch_rvalid_o <= fetch_gnt_o & ~fetch_we_i;
      store_rvalid_o <= store_gnt_o & ~store_we_i;
      bus_rvalid_o   <= bus_gnt_o & ~bus_we_i;
    end
  end

endmodule

//--- verilog/scratch_mem.sv
`timescale 1ns/1ps

module scratch_mem #(
  parameter int ADDR_W = 6,
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              en_i,
  input  logic              we_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  output logic [DATA_W-1:0] rdata_o
);

  logic [DATA_W-1:0] mem_q [2**ADDR_W];

  // Read returns the old contents on a write
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule
